// File: hdl/flappy_params.svh
// Game constants
// Playfield, start positions, motion and hit margins
`ifndef FLAPPY_PARAMS_SVH
`define FLAPPY_PARAMS_SVH

// Playfield
`define FIELD_WIDTH 160
`define FIELD_FLOOR 116

// Bird column and start height
`define BIRD_X 20
`define BIRD_Y0 40
`define FLAP_RISE 4
`define FALL_STEP 2

// Food start positions, items 1 to 3
`define FOOD_X0_1 112
`define FOOD_X0_2 165
`define FOOD_X0_3 218
`define FOOD_Y0_1 105
`define FOOD_Y0_2 65
`define FOOD_Y0_3 90
`define FOOD_SPACING 53
`define FOOD_Y_BASE 10

// Tree placement relative to its food item
`define TREE_DX 2
`define TREE_DY 6

// Hit and eat margins
`define TREE_LEFT 9
`define TREE_RIGHT 5
`define TREE_TOP 4
`define EAT_RANGE 4

`endif

// File: hdl/flappy_pkg.sv
// Game types
package flappy_pkg;

    typedef logic [8:0] x_coord_t;
    // Height grows downwards, zero is the top row
    typedef logic [6:0] y_coord_t;
    typedef logic [7:0] score_t;

    typedef struct packed {
        x_coord_t x;
        y_coord_t y;
        logic     eaten;
    } food_pos_t;

    // Element 0 is food item 1
    typedef struct packed {
        y_coord_t            bird_y;
        food_pos_t [2:0]     food;
    } world_t;

    typedef struct packed {
        y_coord_t bird_y;
        score_t   score;
        logic     over;
    } game_status_t;

    typedef enum logic [1:0] {IDLE, UPDATE, JUDGE, ACK} seq_state_t;

endpackage

// File: hdl/step_sequencer.sv
// Step handshake and play/over control
`timescale 1ns/10ps

module step_sequencer (
    input  logic clock,
    input  logic reset,
    input  logic step_req,
    input  logic flap,
    input  logic start,
    input  logic hit,
    output logic step_ack,
    output logic update_en,
    output logic restart_en,
    output logic flap_en,
    output logic judge_en,
    output logic over
);

    flappy_pkg::seq_state_t state;
    flappy_pkg::seq_state_t state_next;
    logic                   flap_q;
    logic                   start_q;

    always_comb begin
        state_next = state;
        case (state)
            flappy_pkg::IDLE: begin
                if (step_req) begin
                    state_next = flappy_pkg::UPDATE;
                end
            end
            flappy_pkg::UPDATE: state_next = flappy_pkg::JUDGE;
            flappy_pkg::JUDGE:  state_next = flappy_pkg::ACK;
            // Hold here as long as the requester keeps step_req high
            flappy_pkg::ACK: begin
                if (!step_req) begin
                    state_next = flappy_pkg::IDLE;
                end
            end
            default: state_next = flappy_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            state    <= flappy_pkg::IDLE;
            step_ack <= 1'b0;
            over     <= 1'b0;
        end else begin
            state    <= state_next;
            // Registered, so ack follows ACK state by one cycle both ways
            step_ack <= (state == flappy_pkg::ACK);
            if (restart_en) begin
                over <= 1'b0;
            end else if (state == flappy_pkg::ACK && hit) begin
                over <= 1'b1;
            end
        end
    end

    // Player inputs captured with the request
    always_ff @(posedge clock) begin
        if (state == flappy_pkg::IDLE && step_req) begin
            flap_q  <= flap;
            start_q <= start;
        end
    end

    // Moves only in play, restart only from game over with start
    assign update_en  = (state == flappy_pkg::UPDATE) && !over;
    assign flap_en    = (state == flappy_pkg::UPDATE) && flap_q;
    assign restart_en = (state == flappy_pkg::UPDATE) && over && start_q;
    assign judge_en   = (state == flappy_pkg::JUDGE) && !over;

endmodule

// File: hdl/world_update.sv
// World state registers
// Bird height, food items and food height generator
`timescale 1ns/10ps
`include "flappy_params.svh"

module world_update (
    input  logic               clock,
    input  logic               reset,
    input  logic               update_en,
    input  logic               restart_en,
    input  logic               flap_en,
    input  logic [2:0]         eaten,
    output flappy_pkg::world_t world
);

    localparam flappy_pkg::y_coord_t BIRD_START = `BIRD_Y0;
    localparam flappy_pkg::y_coord_t RISE = `FLAP_RISE;
    localparam flappy_pkg::y_coord_t FALL = `FALL_STEP;
    localparam flappy_pkg::x_coord_t SPACING = `FOOD_SPACING;
    localparam flappy_pkg::y_coord_t Y_BASE = `FOOD_Y_BASE;
    localparam flappy_pkg::y_coord_t GEN_OFFSET = 20;
    localparam flappy_pkg::x_coord_t START_X [3] = '{`FOOD_X0_1, `FOOD_X0_2, `FOOD_X0_3};
    localparam flappy_pkg::y_coord_t START_Y [3] = '{`FOOD_Y0_1, `FOOD_Y0_2, `FOOD_Y0_3};
    localparam logic [3:0] RAN4_SEED = 4'b1110;
    localparam logic [5:0] RAN6_SEED = 6'b111110;

    flappy_pkg::y_coord_t bird_y;
    flappy_pkg::x_coord_t food_x [3];
    flappy_pkg::y_coord_t food_y [3];
    logic [3:0]           ran4;
    logic [5:0]           ran6;
    logic [2:0]           at_zero;
    logic [2:0]           respawn;
    flappy_pkg::y_coord_t food_y_new;

    always_comb begin
        for (int i = 0; i < 3; i++) begin
            at_zero[i] = (food_x[i] == '0);
        end
    end

    // Only the first item at column zero respawns, item 1 first
    assign respawn = at_zero & ~{at_zero[1] | at_zero[0], at_zero[0], 1'b0};

    // Max 10 + 15 + 63 + 20, fits the height range
    assign food_y_new = Y_BASE + flappy_pkg::y_coord_t'(ran4)
                      + flappy_pkg::y_coord_t'(ran6) + GEN_OFFSET;

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            bird_y <= BIRD_START;
            ran4   <= RAN4_SEED;
            ran6   <= RAN6_SEED;
            for (int i = 0; i < 3; i++) begin
                food_x[i] <= START_X[i];
                food_y[i] <= START_Y[i];
            end
        end else if (restart_en) begin
            bird_y <= BIRD_START;
            ran4   <= RAN4_SEED;
            ran6   <= RAN6_SEED;
            for (int i = 0; i < 3; i++) begin
                food_x[i] <= START_X[i];
                food_y[i] <= START_Y[i];
            end
        end else if (update_en) begin
            if (flap_en) begin
                bird_y <= bird_y - RISE;
            end else begin
                bird_y <= bird_y + FALL;
            end
            // Generator steps once per game step
            ran4 <= {ran4[2:0], ran4[3] ^ ran4[2]};
            ran6 <= {ran6[4:0], ran6[5] ^ ran6[3] ^ ran6[2]};
            // Respawn goes behind the item before it in the ring
            for (int i = 0; i < 3; i++) begin
                if (respawn[i]) begin
                    food_x[i] <= food_x[(i + 2) % 3] + SPACING;
                    food_y[i] <= food_y_new;
                end else if (at_zero == '0) begin
                    food_x[i] <= food_x[i] - 9'd1;
                end
            end
        end
    end

    always_comb begin
        world.bird_y = bird_y;
        for (int i = 0; i < 3; i++) begin
            world.food[i].x     = food_x[i];
            world.food[i].y     = food_y[i];
            world.food[i].eaten = eaten[i];
        end
    end

endmodule

// File: hdl/collision_judge.sv
// Hit test, food eating and score
`timescale 1ns/10ps
`include "flappy_params.svh"

module collision_judge (
    input  logic               clock,
    input  logic               reset,
    input  logic               judge_en,
    input  logic               restart_en,
    input  flappy_pkg::world_t world,
    output logic               hit,
    output logic [2:0]         eaten,
    output flappy_pkg::score_t score
);

    localparam flappy_pkg::x_coord_t BIRD_COL = `BIRD_X;
    localparam flappy_pkg::y_coord_t FLOOR = `FIELD_FLOOR;
    localparam flappy_pkg::x_coord_t TREE_DX = `TREE_DX;
    localparam flappy_pkg::y_coord_t TREE_DY = `TREE_DY;
    localparam flappy_pkg::x_coord_t TREE_LEFT = `TREE_LEFT;
    localparam flappy_pkg::x_coord_t TREE_RIGHT = `TREE_RIGHT;
    localparam flappy_pkg::y_coord_t TREE_TOP = `TREE_TOP;
    localparam flappy_pkg::x_coord_t EAT_X = `EAT_RANGE;
    localparam flappy_pkg::y_coord_t EAT_Y = `EAT_RANGE;

    flappy_pkg::x_coord_t tree_x [3];
    flappy_pkg::y_coord_t tree_top [3];
    logic                 edge_hit;
    logic [2:0]           tree_hit;
    logic [2:0]           near;
    logic [2:0]           gone;

    always_comb begin
        // Ceiling at zero, ground from the floor row down
        edge_hit = (world.bird_y == '0) || (world.bird_y >= FLOOR);
        for (int i = 0; i < 3; i++) begin
            tree_x[i]   = world.food[i].x + TREE_DX;
            tree_top[i] = world.food[i].y + TREE_DY;
            tree_hit[i] = (BIRD_COL > tree_x[i] - TREE_LEFT)
                       && (BIRD_COL < tree_x[i] + TREE_RIGHT)
                       && (world.bird_y > tree_top[i] - TREE_TOP);
            // Only food that is still there can be eaten
            near[i] = !world.food[i].eaten
                   && (BIRD_COL > world.food[i].x - EAT_X)
                   && (BIRD_COL < world.food[i].x + EAT_X)
                   && (world.bird_y > world.food[i].y - EAT_Y)
                   && (world.bird_y < world.food[i].y + EAT_Y);
            gone[i] = (world.food[i].x == '0);
        end
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            hit   <= 1'b0;
            eaten <= '0;
            score <= '0;
        end else if (restart_en) begin
            hit   <= 1'b0;
            eaten <= '0;
            score <= '0;
        end else if (judge_en) begin
            hit   <= edge_hit || (|tree_hit);
            // Flag drops on the step the item is about to respawn
            eaten <= (eaten & ~gone) | near;
            if (|near) begin
                score <= score + 8'd1;
            end
        end
    end

endmodule

// File: hdl/flappy_core.sv
// Flying game core
`timescale 1ns/10ps

module flappy_core (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     step_req,
    input  logic                     flap,
    input  logic                     start,
    output logic                     step_ack,
    output flappy_pkg::game_status_t status
);

    logic                 update_en;
    logic                 restart_en;
    logic                 flap_en;
    logic                 judge_en;
    logic                 over;
    logic                 hit;
    logic [2:0]           eaten;
    flappy_pkg::world_t   world;
    flappy_pkg::score_t   score;

    step_sequencer seq0 (
        .clock      (clock),
        .reset      (reset),
        .step_req   (step_req),
        .flap       (flap),
        .start      (start),
        .hit        (hit),
        .step_ack   (step_ack),
        .update_en  (update_en),
        .restart_en (restart_en),
        .flap_en    (flap_en),
        .judge_en   (judge_en),
        .over       (over)
    );

    world_update world0 (
        .clock      (clock),
        .reset      (reset),
        .update_en  (update_en),
        .restart_en (restart_en),
        .flap_en    (flap_en),
        .eaten      (eaten),
        .world      (world)
    );

    collision_judge judge0 (
        .clock      (clock),
        .reset      (reset),
        .judge_en   (judge_en),
        .restart_en (restart_en),
        .world      (world),
        .hit        (hit),
        .eaten      (eaten),
        .score      (score)
    );

    assign status = '{bird_y: world.bird_y, score: score, over: over};

endmodule

// File: testbench/flappy_tb.sv
// Testbench for the flying game core
`timescale 1ns/10ps

module flappy_tb;

    localparam int ACK_LATENCY = 3;
    localparam int ACK_WAIT = 20;

    typedef struct packed {
        logic [127:0]          name;
        logic [15:0]           count;
        logic                  flap;
        logic                  start;
        flappy_pkg::y_coord_t  bird_y;
        flappy_pkg::score_t    score;
        logic                  over;
    } test_rec_t;

    logic                      clock;
    logic                      reset;
    logic                      step_req;
    logic                      flap;
    logic                      start;
    logic                      step_ack;
    flappy_pkg::game_status_t  status;

    test_rec_t tests [$];
    int        total_steps = 0;
    int        error_count = 0;
    int        check_count = 0;
    int        cycle_count = 0;
    int        cycle_limit = 0;

    flappy_core dut0 (
        .clock    (clock),
        .reset    (reset),
        .step_req (step_req),
        .flap     (flap),
        .start    (start),
        .step_ack (step_ack),
        .status   (status)
    );

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    // Run length bound set once the records are known
    always @(posedge clock) begin
        cycle_count = cycle_count + 1;
        if (cycle_limit != 0 && cycle_count > cycle_limit) begin
            $display("timeout: run went past %0d cycles, errors so far %0d",
                     cycle_limit, error_count);
            $display("tests failed");
            $finish;
        end
    end

    task automatic load_tests();
        int           fd;
        int           n;
        string        line;
        logic [127:0] name_buf;
        int           count_v;
        int           flap_v;
        int           start_v;
        int           bird_v;
        int           score_v;
        int           over_v;
        test_rec_t    rec;
        fd = $fopen("testbench/flappy_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open the test file testbench/flappy_tests.txt");
            error_count++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                // Lines starting with # describe the columns
                if (n > 0 && line.substr(0, 0) != "#") begin
                    n = $sscanf(line, "%s %d %d %d %d %d %d", name_buf, count_v,
                                flap_v, start_v, bird_v, score_v, over_v);
                    if (n == 7) begin
                        rec.name   = name_buf;
                        rec.count  = count_v[15:0];
                        rec.flap   = flap_v[0];
                        rec.start  = start_v[0];
                        rec.bird_y = bird_v[6:0];
                        rec.score  = score_v[7:0];
                        rec.over   = over_v[0];
                        tests.push_back(rec);
                        total_steps += count_v;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // One four-phase handshake entered and left on a falling edge
    task automatic run_step(input logic flap_in, input logic start_in,
                            input logic [127:0] name);
        int waits;
        waits = 0;
        if (step_ack) begin
            $display("step_ack was already high before the request in %0s", name);
            error_count++;
        end
        step_req = 1'b1;
        flap     = flap_in;
        start    = start_in;
        while (!step_ack && waits < ACK_WAIT) begin
            @(negedge clock);
            waits++;
        end
        // First falling edge follows the request edge
        if (!step_ack) begin
            $display("no step_ack within %0d cycles in %0s", ACK_WAIT, name);
            error_count++;
        end else if (waits - 1 != ACK_LATENCY) begin
            $display("CHECK FAILED %0s: ack latency expected %0d, actual %0d",
                     name, ACK_LATENCY, waits - 1);
            error_count++;
        end
        step_req = 1'b0;
        flap     = 1'b0;
        start    = 1'b0;
        waits    = 0;
        while (step_ack && waits < ACK_WAIT) begin
            @(negedge clock);
            waits++;
        end
        if (step_ack) begin
            $display("step_ack stayed high after step_req dropped in %0s", name);
            error_count++;
        end
    endtask

    task automatic check_status(input test_rec_t rec);
        check_count++;
        if (status.bird_y !== rec.bird_y) begin
            $display("CHECK FAILED %0s: bird_y expected %0d, actual %0d",
                     rec.name, rec.bird_y, status.bird_y);
            error_count++;
        end
        if (status.score !== rec.score) begin
            $display("CHECK FAILED %0s: score expected %0d, actual %0d",
                     rec.name, rec.score, status.score);
            error_count++;
        end
        if (status.over !== rec.over) begin
            $display("CHECK FAILED %0s: over expected %0d, actual %0d",
                     rec.name, rec.over, status.over);
            error_count++;
        end
    endtask

    initial begin
        reset    = 1'b0;
        step_req = 1'b0;
        flap     = 1'b0;
        start    = 1'b0;
        load_tests();
        cycle_limit = total_steps * 10 + 100;
        repeat (16) @(negedge clock);
        reset = 1'b1;
        @(negedge clock);
        if (tests.size() == 0) begin
            $display("no test records were read from the test file");
            error_count++;
        end
        foreach (tests[i]) begin
            for (int n = 0; n < int'(tests[i].count); n++) begin
                run_step(tests[i].flap, tests[i].start, tests[i].name);
            end
            check_status(tests[i]);
        end
        $display("records: %0d, checks: %0d, errors: %0d",
                 tests.size(), check_count, error_count);
        if (error_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// File: project.f
+incdir+hdl
hdl/flappy_pkg.sv
hdl/step_sequencer.sv
hdl/world_update.sv
hdl/collision_judge.sv
hdl/flappy_core.sv
testbench/flappy_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the flying game testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal -f project.f --top-module flappy_tb -o flappy_sim
./obj_dir/flappy_sim | tee sim.log

if grep -qx "all tests passed" sim.log; then
    echo "RESULT: PASS"
else
    echo "RESULT: FAIL"
    exit 1
fi

// File: testbench/flappy_tests.txt
# name count flap start bird_y score over
# status is checked after the last step of each record, count 0 checks only
reset_state 0 0 0 40 0 0
fall 10 0 0 60 0 0
flap_one 1 1 0 56 0 0
cycle_flap 1 1 0 52 0 0
cycle_fall 2 0 0 56 0 0
ceiling 14 1 0 0 0 1
over_hold 3 1 0 0 0 1
restart 1 0 1 40 0 0
eat_fall 30 0 0 100 0 0
eat_climb 19 1 0 24 0 0
eat_descend 41 0 0 106 1 0
pass_climb 8 1 0 74 1 0
pass_fall 10 0 0 94 1 0
